/* src/spi_debug_pkg.sv */
package spi_debug_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;     // One instruction per core cycle.
    localparam int LED_WIDTH = 3;
    localparam int REG_SEL_WIDTH = 5;

    // Word replies are preceded by a byte that carries this count.
    localparam logic [7:0] REPLY_BYTES = 8'(XLEN / 8);

    typedef enum logic [7:0] {
        CMD_NOP           = 8'h00,
        CMD_ECHO          = 8'h01,
        CMD_TOGGLE_LED    = 8'h02,
        CMD_ENABLE_CLOCK  = 8'h03,
        CMD_DISABLE_CLOCK = 8'h04,
        CMD_STEP_CLOCK    = 8'h05,
        CMD_GET_PC        = 8'h06,
        CMD_GET_REG       = 8'h07,
        CMD_READ_FLASH    = 8'h08,
        CMD_ECHO_CC       = 8'hCC
    } dbg_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ECHO,
        ST_READ_REG,
        ST_REPLYING
    } dbg_state_e;

endpackage

/* src/spi_target.sv */
module spi_target (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       ss_n,
    output logic       miso,
    input  logic [7:0] tx_byte,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] ss_sync;
    logic       sclk_q;
    logic       ss_q;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       ss_fall;
    logic       ss_active;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;
    logic       load_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            ss_sync   <= 2'b11;                    // Deselected until the host says otherwise.
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            ss_sync   <= {ss_sync[0], ss_n};
        end
    end

    assign ss_active = ~ss_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_q;
    assign sclk_fall = ~sclk_sync[1] & sclk_q;
    assign ss_fall   = ~ss_sync[1] & ss_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_q   <= 1'b0;
            ss_q     <= 1'b1;
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end else begin
            sclk_q   <= sclk_sync[1];
            ss_q     <= ss_sync[1];
            rx_valid <= 1'b0;
            if (!ss_active) begin
                bit_cnt <= 3'd0;                   // A new select always starts on a byte boundary.
            end else if (sclk_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;
                rx_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ss_active && sclk_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {rx_shift, mosi_sync[1]};
            end
        end
    end

    // The reply byte is taken one clk after the strobe so that the controller has updated it.
    always_ff @(posedge clk) begin
        if (rst) begin
            load_req <= 1'b0;
            tx_shift <= 8'h00;
        end else begin
            load_req <= rx_valid | ss_fall;
            if (load_req) begin
                tx_shift <= tx_byte;
            end else if (ss_active && sclk_fall && bit_cnt != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    // The falling edge after the last bit leaves the freshly loaded byte in place.
    assign miso = ss_active & tx_shift[7];

endmodule

/* src/debug_cmd_ctrl.sv */
module debug_cmd_ctrl (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [7:0]                              rx_byte,
    input  logic                                    rx_valid,
    output logic [7:0]                              tx_byte,
    output logic                                    core_tick,
    output logic [spi_debug_pkg::REG_SEL_WIDTH-1:0] reg_sel,
    input  logic [spi_debug_pkg::XLEN-1:0]          pc,
    input  logic [spi_debug_pkg::XLEN-1:0]          reg_data,
    output logic                                    led_toggle
);

    spi_debug_pkg::dbg_state_e     state;
    spi_debug_pkg::dbg_cmd_e       cmd;
    logic [spi_debug_pkg::XLEN-1:0] send_buf;
    logic [7:0]                    send_cnt;
    logic                          clk_en;
    logic                          step_pend;

    assign cmd       = spi_debug_pkg::dbg_cmd_e'(rx_byte);
    assign reg_sel   = rx_byte[spi_debug_pkg::REG_SEL_WIDTH-1:0]; // Index byte of GET_REG.
    assign core_tick = clk_en | step_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_byte    <= 8'h00;
            state      <= spi_debug_pkg::ST_IDLE;
            send_cnt   <= 8'd0;
            clk_en     <= 1'b1;
            step_pend  <= 1'b0;
            led_toggle <= 1'b0;
        end else begin
            step_pend <= 1'b0;
            if (rx_valid) begin
                case (state)
                    spi_debug_pkg::ST_IDLE: begin
                        case (cmd)
                            spi_debug_pkg::CMD_NOP: begin
                                tx_byte <= 8'h00;
                            end
                            spi_debug_pkg::CMD_ECHO: begin
                                tx_byte <= spi_debug_pkg::CMD_ECHO;
                                state   <= spi_debug_pkg::ST_ECHO;
                            end
                            spi_debug_pkg::CMD_TOGGLE_LED: begin
                                tx_byte    <= 8'h00;
                                led_toggle <= ~led_toggle;
                            end
                            spi_debug_pkg::CMD_ENABLE_CLOCK: begin
                                tx_byte <= 8'h00;
                                clk_en  <= 1'b1;
                            end
                            spi_debug_pkg::CMD_DISABLE_CLOCK: begin
                                tx_byte <= 8'h00;
                                clk_en  <= 1'b0;
                            end
                            spi_debug_pkg::CMD_STEP_CLOCK: begin
                                tx_byte   <= 8'h00;
                                step_pend <= ~clk_en;  // A running core needs no extra tick.
                            end
                            spi_debug_pkg::CMD_GET_PC: begin
                                tx_byte  <= spi_debug_pkg::REPLY_BYTES;
                                send_cnt <= spi_debug_pkg::REPLY_BYTES;
                                state    <= spi_debug_pkg::ST_REPLYING;
                            end
                            spi_debug_pkg::CMD_GET_REG: begin
                                tx_byte <= 8'h00;
                                state   <= spi_debug_pkg::ST_READ_REG;
                            end
                            spi_debug_pkg::CMD_ECHO_CC: begin
                                tx_byte <= 8'hCC;
                            end
                            default: begin
                                tx_byte <= 8'hFF;      // No flash here, so READ_FLASH lands here too.
                            end
                        endcase
                    end
                    spi_debug_pkg::ST_ECHO: begin
                        tx_byte <= rx_byte;
                        state   <= spi_debug_pkg::ST_IDLE;
                    end
                    spi_debug_pkg::ST_READ_REG: begin
                        tx_byte  <= 8'h00;
                        send_cnt <= spi_debug_pkg::REPLY_BYTES;
                        state    <= spi_debug_pkg::ST_REPLYING;
                    end
                    spi_debug_pkg::ST_REPLYING: begin
                        tx_byte  <= send_buf[spi_debug_pkg::XLEN-1 -: 8];
                        send_cnt <= send_cnt - 8'd1;
                        if (send_cnt == 8'd1) begin
                            state <= spi_debug_pkg::ST_IDLE;
                        end
                    end
                    default: begin
                        tx_byte <= 8'hFF;
                        state   <= spi_debug_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

    // Word being returned, most significant byte first.
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (state == spi_debug_pkg::ST_IDLE && cmd == spi_debug_pkg::CMD_GET_PC) begin
                send_buf <= pc;
            end else if (state == spi_debug_pkg::ST_READ_REG) begin
                send_buf <= reg_data;
            end else if (state == spi_debug_pkg::ST_REPLYING) begin
                send_buf <= send_buf << 8;
            end
        end
    end

endmodule

/* src/step_core.sv */
module step_core (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    core_tick,
    input  logic [spi_debug_pkg::REG_SEL_WIDTH-1:0] reg_sel,
    output logic [spi_debug_pkg::XLEN-1:0]          reg_data,
    output logic [spi_debug_pkg::XLEN-1:0]          pc,
    output logic [spi_debug_pkg::LED_WIDTH-1:0]     gpio
);

    logic [spi_debug_pkg::XLEN-1:0]          regs [0:2**spi_debug_pkg::REG_SEL_WIDTH-1];
    logic [spi_debug_pkg::REG_SEL_WIDTH-1:0] wr_sel;

    assign wr_sel = pc[spi_debug_pkg::REG_SEL_WIDTH+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= spi_debug_pkg::RESET_PC;
        end else if (core_tick) begin
            pc <= pc + spi_debug_pkg::PC_STEP;
        end
    end

    // Each cycle leaves a trace of the old PC, so the register contents follow from the PC.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**spi_debug_pkg::REG_SEL_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (core_tick && wr_sel != '0) begin
            regs[wr_sel] <= pc;                    // Register 0 is never written.
        end
    end

    assign reg_data = regs[reg_sel];
    assign gpio     = pc[spi_debug_pkg::LED_WIDTH+1:2];

endmodule

/* src/spi_debug_soc.sv */
module spi_debug_soc (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                spi_sclk,
    input  logic                                spi_mosi,
    input  logic                                spi_ss_n,
    output logic                                spi_miso,
    output logic [spi_debug_pkg::LED_WIDTH-1:0] led
);

    logic [7:0]                              tx_byte;
    logic [7:0]                              rx_byte;
    logic                                    rx_valid;
    logic                                    core_tick;
    logic [spi_debug_pkg::REG_SEL_WIDTH-1:0] reg_sel;
    logic [spi_debug_pkg::XLEN-1:0]          pc;
    logic [spi_debug_pkg::XLEN-1:0]          reg_data;
    logic                                    led_toggle;
    logic [spi_debug_pkg::LED_WIDTH-1:0]     gpio;

    spi_target i_spi (
        .clk      (clk),
        .rst      (rst),
        .sclk     (spi_sclk),
        .mosi     (spi_mosi),
        .ss_n     (spi_ss_n),
        .miso     (spi_miso),
        .tx_byte  (tx_byte),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    debug_cmd_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .tx_byte    (tx_byte),
        .core_tick  (core_tick),
        .reg_sel    (reg_sel),
        .pc         (pc),
        .reg_data   (reg_data),
        .led_toggle (led_toggle)
    );

    step_core i_core (
        .clk       (clk),
        .rst       (rst),
        .core_tick (core_tick),
        .reg_sel   (reg_sel),
        .reg_data  (reg_data),
        .pc        (pc),
        .gpio      (gpio)
    );

    // The debug toggle shares bit 0 with the core's own output.
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else begin
            led <= gpio | {{(spi_debug_pkg::LED_WIDTH-1){1'b0}}, led_toggle};
        end
    end

endmodule

/* bench/spi_host_bfm.sv */
module spi_host_bfm (
    input  logic clk,
    input  logic miso,
    output logic sclk,
    output logic mosi,
    output logic ss_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT_CLKS    = 8;
    localparam int HALF_CLKS   = BIT_CLKS / 2;
    localparam int SELECT_CLKS = 8;            // Target reloads its reply after the select edge.
    localparam int GAP_CLKS    = 8;

    initial begin
        sclk = 1'b0;
        mosi = 1'b0;
        ss_n = 1'b1;
    end

    // One mode-0 frame: select, eight bits MSB first, deselect.
    task automatic exchange_byte(input logic [7:0] tx_data, output logic [7:0] rx_data);
        logic [7:0] sampled;
        int         bit_idx;
        sampled = 8'h00;
        @(posedge clk);
        ss_n <= 1'b0;
        mosi <= tx_data[7];
        repeat (SELECT_CLKS) @(posedge clk);
        for (bit_idx = 7; bit_idx >= 0; bit_idx--) begin
            mosi <= tx_data[bit_idx];
            repeat (HALF_CLKS) @(posedge clk);
            sclk <= 1'b1;
            repeat (HALF_CLKS - 1) @(posedge clk);
            @(negedge clk);
            sampled[bit_idx] = miso;           // MISO has settled since the last falling edge.
            @(posedge clk);
            sclk <= 1'b0;
        end
        repeat (HALF_CLKS) @(posedge clk);
        ss_n <= 1'b1;
        repeat (GAP_CLKS) @(posedge clk);
        rx_data = sampled;
    endtask

endmodule

/* bench/spi_debug_tb.sv */
module spi_debug_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          RESET_CYCLES   = 16;
    localparam int          BYTE_CYCLES    = 100;  // Frame of 64 clk plus select setup and gap.
    localparam int          MAX_BYTES      = 100;
    localparam int          TIMEOUT_CYCLES = 2 * MAX_BYTES * BYTE_CYCLES;
    localparam logic [31:0] RAND_SEED      = 32'h6b00_3d7e;
    localparam logic [7:0]  FILLER         = 8'h00;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                spi_sclk;
    logic                                spi_mosi;
    logic                                spi_ss_n;
    logic                                spi_miso;
    logic [spi_debug_pkg::LED_WIDTH-1:0] led;
    int                                  cycle_count = 0;
    int                                  fail_count;
    logic                                toggle_state;

    spi_debug_soc i_dut (
        .clk      (clk),
        .rst      (rst),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_ss_n (spi_ss_n),
        .spi_miso (spi_miso),
        .led      (led)
    );

    spi_host_bfm i_host (
        .clk  (clk),
        .miso (spi_miso),
        .sclk (spi_sclk),
        .mosi (spi_mosi),
        .ss_n (spi_ss_n)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("The run timed out after %0d clock cycles without finishing", cycle_count);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic fail_run(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        fail_count++;
        $display("FAIL %s expected %h actual %h", name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else fail_run(name, expected, actual);
    endtask

    // Word replies arrive MSB first, one byte per filler.
    task automatic collect_word(output logic [31:0] word);
        logic [7:0] rx;
        int         n;
        word = '0;
        for (n = 0; n < 4; n++) begin
            i_host.exchange_byte(FILLER, rx);
            word = {word[23:0], rx};
        end
    endtask

    task automatic read_pc(input string name, output logic [31:0] value);
        logic [7:0] rx;
        i_host.exchange_byte(spi_debug_pkg::CMD_GET_PC, rx);
        i_host.exchange_byte(FILLER, rx);
        check_word({name, "_count"}, 32'd4, 32'(rx));
        collect_word(value);
    endtask

    task automatic read_reg(input string name, input logic [4:0] index,
                            output logic [31:0] value);
        logic [7:0] rx;
        i_host.exchange_byte(spi_debug_pkg::CMD_GET_REG, rx);
        i_host.exchange_byte({3'b000, index}, rx);
        check_word({name, "_cmd_ack"}, 32'd0, 32'(rx));
        i_host.exchange_byte(FILLER, rx);
        check_word({name, "_index_ack"}, 32'd0, 32'(rx));
        collect_word(value);
    endtask

    // Register k holds the most recent PC below stop_pc whose bits [6:2] equal k.
    function automatic logic [31:0] expected_reg(input logic [31:0] stop_pc,
                                                 input logic [4:0] index);
        logic [4:0] last_idx;
        logic [5:0] back;
        if (index == 5'd0) begin
            return 32'd0;
        end
        last_idx = 5'((stop_pc - 32'd4) >> 2);
        back     = 6'(5'(last_idx - index)) + 6'd1;
        return stop_pc - 32'(back) * 32'd4;
    endfunction

    function automatic logic [2:0] expected_led(input logic [31:0] pc_value, input logic toggle);
        return {pc_value[4:3], pc_value[2] | toggle};
    endfunction

    task automatic fixed_replies();
        logic [7:0] cmds [5];
        logic [7:0] replies [5];
        logic [7:0] rx;
        int         n;
        cmds    = '{8'h00, 8'h02, 8'hCC, 8'h08, 8'h5A};
        replies = '{8'h00, 8'h00, 8'hCC, 8'hFF, 8'hFF};
        for (n = 0; n < 5; n++) begin
            i_host.exchange_byte(cmds[n], rx);
            i_host.exchange_byte(FILLER, rx);
            check_word($sformatf("fixed_reply_%02h", cmds[n]), 32'(replies[n]), 32'(rx));
            if (cmds[n] == spi_debug_pkg::CMD_TOGGLE_LED) begin
                toggle_state = ~toggle_state;
            end
        end
    endtask

    task automatic echo_roundtrip();
        logic [7:0] payload;
        logic [7:0] rx;
        payload = 8'($urandom());
        i_host.exchange_byte(spi_debug_pkg::CMD_ECHO, rx);
        i_host.exchange_byte(payload, rx);
        check_word("echo_ack", 32'h01, 32'(rx));
        i_host.exchange_byte(FILLER, rx);
        check_word("echo_payload", 32'(payload), 32'(rx));
    endtask

    task automatic stop_and_step(output logic [31:0] stop_pc);
        logic [7:0]  rx;
        logic [31:0] first_pc;
        logic [31:0] stepped_pc;
        logic [31:0] held_pc;
        int          steps;
        int          n;
        steps = 1 + int'($urandom() % 8);
        i_host.exchange_byte(spi_debug_pkg::CMD_DISABLE_CLOCK, rx);
        read_pc("stop_pc", first_pc);
        for (n = 0; n < steps; n++) begin
            i_host.exchange_byte(spi_debug_pkg::CMD_STEP_CLOCK, rx);
        end
        read_pc("step_pc", stepped_pc);
        check_word($sformatf("step_pc_%0d_steps", steps), first_pc + 32'(4 * steps),
                   stepped_pc);
        read_pc("hold_pc", held_pc);
        check_word("hold_pc", stepped_pc, held_pc);  // No ticks while stopped.
        stop_pc = held_pc;
    endtask

    task automatic register_reads(input logic [31:0] stop_pc);
        logic [4:0]  last_idx;
        logic [4:0]  rand_idx;
        logic [31:0] value;
        last_idx = 5'((stop_pc - 32'd4) >> 2);
        read_reg("reg_last", last_idx, value);
        check_word("reg_last", (last_idx == 5'd0) ? 32'd0 : stop_pc - 32'd4, value);
        read_reg("reg_zero", 5'd0, value);
        check_word("reg_zero", 32'd0, value);
        rand_idx = 5'($urandom());
        read_reg("reg_random", rand_idx, value);
        check_word($sformatf("reg_random_%0d", rand_idx), expected_reg(stop_pc, rand_idx),
                   value);
    endtask

    task automatic led_state(input logic [31:0] stop_pc);
        logic [7:0]  rx;
        logic [31:0] led_pc;
        led_pc = stop_pc;
        if (led_pc[2]) begin
            i_host.exchange_byte(spi_debug_pkg::CMD_STEP_CLOCK, rx);
            led_pc = led_pc + 32'd4;  // Bit 2 is now clear and bit 0 shows only the toggle.
        end
        @(negedge clk);
        check_word("led_stopped", 32'(expected_led(led_pc, toggle_state)), 32'(led));
        i_host.exchange_byte(spi_debug_pkg::CMD_TOGGLE_LED, rx);
        toggle_state = ~toggle_state;
        @(negedge clk);
        check_word("led_toggled", 32'(expected_led(led_pc, toggle_state)), 32'(led));
    endtask

    task automatic clock_restart();
        logic [7:0]  rx;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        i_host.exchange_byte(spi_debug_pkg::CMD_ENABLE_CLOCK, rx);
        read_pc("run_pc_a", pc_a);
        read_pc("run_pc_b", pc_b);
        assert (pc_b > pc_a) else fail_run("run_pc_advance", pc_a + 32'd4, pc_b);
        check_word("run_pc_align", 32'd0, (pc_b - spi_debug_pkg::RESET_PC) & 32'd3);
    endtask

    initial begin
        logic [31:0] stop_pc;
        rst          = 1'b1;
        fail_count   = 0;
        toggle_state = 1'b0;
        void'($urandom(RAND_SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        fixed_replies();
        echo_roundtrip();
        stop_and_step(stop_pc);
        register_reads(stop_pc);
        led_state(stop_pc);
        clock_restart();

        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* compile.f */
src/spi_debug_pkg.sv
src/spi_target.sv
src/debug_cmd_ctrl.sv
src/step_core.sv
src/spi_debug_soc.sv
bench/spi_host_bfm.sv
bench/spi_debug_tb.sv
